//--- common/pipe_config.svh
`ifndef PIPE_CONFIG_SVH
`define PIPE_CONFIG_SVH

// Register and data memory word width
`define PIPE_DATA_W 16

// Architectural registers, so indices are 3 bits
`define PIPE_REGS 8

// Data memory words, addressed by the 8-bit immediate
`define PIPE_MEM_DEPTH 256

// Instruction tag width, tags wrap around
`define PIPE_TAG_W 8

// Per-stage stall counters, saturating at all ones
`define PIPE_STALL_W 4

`endif

//--- common/pipe_pkg.sv
`include "pipe_config.svh"

package pipe_pkg;

    typedef logic [`PIPE_DATA_W-1:0] data_t;
    typedef logic [$clog2(`PIPE_REGS)-1:0] reg_idx_t;
    typedef logic [7:0] imm_t;
    typedef logic [`PIPE_TAG_W-1:0] tag_t;
    typedef logic [`PIPE_STALL_W-1:0] stall_cnt_t;

    // Top three bits of the instruction word, code 7 is unused
    typedef enum logic [2:0] {
        NOP  = 3'd0,
        LI   = 3'd1,
        ADDI = 3'd2,
        ADD  = 3'd3,
        SUB  = 3'd4,
        LD   = 3'd5,
        ST   = 3'd6
    } opcode_t;

    // Operand source for the execute stage
    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,
        FWD_MEM  = 2'd1,
        FWD_WB   = 2'd2
    } fwd_sel_t;

    // Decode to execute
    typedef struct packed {
        opcode_t    op;
        reg_idx_t   rd;
        reg_idx_t   rs;
        data_t      a_val;
        data_t      b_val;
        imm_t       imm;
        tag_t       tag;
        stall_cnt_t fetch_stalls;
        stall_cnt_t decode_stalls;
    } ex_payload_t;

    // Execute to memory, result holds the address for LD and ST
    typedef struct packed {
        opcode_t    op;
        logic       we;
        reg_idx_t   rd;
        data_t      result;
        data_t      store_data;
        tag_t       tag;
        stall_cnt_t fetch_stalls;
        stall_cnt_t decode_stalls;
    } mem_payload_t;

    // Memory to writeback
    typedef struct packed {
        logic       we;
        reg_idx_t   rd;
        data_t      value;
        tag_t       tag;
        stall_cnt_t fetch_stalls;
        stall_cnt_t decode_stalls;
    } wb_payload_t;

endpackage

//--- verilog/stage_reg.sv
module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  payload_t in_payload,
    input  logic     bubble,
    output logic     out_valid,
    output payload_t out_payload
);

    // A bubble empties the stage whatever arrives
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid && !bubble;
        end
    end

    // Payload is only meaningful alongside out_valid
    always_ff @(posedge clk) begin
        out_payload <= in_payload;
    end

endmodule

//--- verilog/pipeline_control.sv
module pipeline_control (
    input  logic                stall,
    output logic                front_hold,
    output logic                ex_bubble,
    input  pipe_pkg::reg_idx_t  ex_rd,
    input  pipe_pkg::reg_idx_t  ex_rs,
    input  logic                mem_valid,
    input  logic                mem_writes,
    input  pipe_pkg::reg_idx_t  mem_rd,
    input  logic                wb_valid,
    input  logic                wb_writes,
    input  pipe_pkg::reg_idx_t  wb_rd,
    output pipe_pkg::fwd_sel_t  fwd_a_sel,
    output pipe_pkg::fwd_sel_t  fwd_b_sel
);

    // Youngest writer wins, so memory is checked before writeback
    function automatic pipe_pkg::fwd_sel_t pick_source(input pipe_pkg::reg_idx_t src);
        pipe_pkg::fwd_sel_t sel;
        if (mem_valid && mem_writes && mem_rd == src) begin
            sel = pipe_pkg::FWD_MEM;
        end else if (wb_valid && wb_writes && wb_rd == src) begin
            sel = pipe_pkg::FWD_WB;
        end else begin
            sel = pipe_pkg::FWD_NONE;
        end
        return sel;
    endfunction

    // Fetch and decode freeze, execute takes a bubble on the same edge
    assign front_hold = stall;
    assign ex_bubble  = stall;

    always_comb begin
        fwd_a_sel = pick_source(ex_rd);
        fwd_b_sel = pick_source(ex_rs);
    end

endmodule

//--- front_end/register_file.sv
`include "pipe_config.svh"

module register_file (
    input  logic               clk,
    input  logic               rst,
    input  logic               we,
    input  pipe_pkg::reg_idx_t waddr,
    input  pipe_pkg::data_t    wdata,
    input  pipe_pkg::reg_idx_t raddr_a,
    input  pipe_pkg::reg_idx_t raddr_b,
    output pipe_pkg::data_t    rdata_a,
    output pipe_pkg::data_t    rdata_b
);

    pipe_pkg::data_t regs [`PIPE_REGS];

    // Same-cycle write is visible to the reader
    function automatic pipe_pkg::data_t read_port(input pipe_pkg::reg_idx_t addr);
        if (we && waddr == addr) begin
            return wdata;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `PIPE_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    always_comb begin
        rdata_a = read_port(raddr_a);
        rdata_b = read_port(raddr_b);
    end

endmodule

//--- front_end/front_end.sv
module front_end (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  instr_valid,
    input  logic [15:0]           instr,
    input  logic                  hold,
    output pipe_pkg::reg_idx_t    rd_addr_a,
    output pipe_pkg::reg_idx_t    rd_addr_b,
    input  pipe_pkg::data_t       rd_data_a,
    input  pipe_pkg::data_t       rd_data_b,
    output logic                  ex_valid,
    output pipe_pkg::ex_payload_t ex_payload
);

    logic                 accept;
    pipe_pkg::tag_t       next_tag;

    // Fetch stage
    logic                 f_valid;
    logic [15:0]          f_instr;
    pipe_pkg::tag_t       f_tag;
    pipe_pkg::stall_cnt_t f_stalls;

    // Decode stage
    logic                 d_valid;
    logic [15:0]          d_instr;
    pipe_pkg::tag_t       d_tag;
    pipe_pkg::stall_cnt_t d_fetch_stalls;
    pipe_pkg::stall_cnt_t d_decode_stalls;

    // Offers during a hold are dropped and use no tag
    assign accept = instr_valid && !hold;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            f_valid  <= 1'b0;
            d_valid  <= 1'b0;
            next_tag <= '0;
        end else begin
            if (!hold) begin
                f_valid <= instr_valid;
                d_valid <= f_valid;
            end
            if (accept) begin
                next_tag <= next_tag + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            f_instr         <= instr;
            f_tag           <= next_tag;
            f_stalls        <= '0;
            d_instr         <= f_instr;
            d_tag           <= f_tag;
            d_fetch_stalls  <= f_stalls;
            d_decode_stalls <= '0;
        end else begin
            // Count held edges per stage, saturating
            if (f_valid && f_stalls != '1) begin
                f_stalls <= f_stalls + 1'b1;
            end
            if (d_valid && d_decode_stalls != '1) begin
                d_decode_stalls <= d_decode_stalls + 1'b1;
            end
        end
    end

    // Register file is read every cycle so a held decode keeps fresh values
    assign rd_addr_a = d_instr[12:10];
    assign rd_addr_b = d_instr[9:7];

    // Field split, the immediate overlaps the low rs bit
    always_comb begin
        ex_payload.op            = pipe_pkg::opcode_t'(d_instr[15:13]);
        ex_payload.rd            = d_instr[12:10];
        ex_payload.rs            = d_instr[9:7];
        ex_payload.a_val         = rd_data_a;
        ex_payload.b_val         = rd_data_b;
        ex_payload.imm           = d_instr[7:0];
        ex_payload.tag           = d_tag;
        ex_payload.fetch_stalls  = d_fetch_stalls;
        ex_payload.decode_stalls = d_decode_stalls;
    end

    assign ex_valid = d_valid;

endmodule

//--- verilog/execute_unit.sv
module execute_unit (
    input  pipe_pkg::ex_payload_t  ex_payload,
    input  pipe_pkg::fwd_sel_t     fwd_a_sel,
    input  pipe_pkg::fwd_sel_t     fwd_b_sel,
    input  pipe_pkg::data_t        mem_fwd_value,
    input  pipe_pkg::data_t        wb_fwd_value,
    output pipe_pkg::mem_payload_t mem_payload
);

    pipe_pkg::data_t op_a;
    pipe_pkg::data_t op_b;
    pipe_pkg::data_t imm_zext;
    pipe_pkg::data_t imm_sext;

    // Operand a is rd, operand b is rs
    always_comb begin
        case (fwd_a_sel)
            pipe_pkg::FWD_MEM: op_a = mem_fwd_value;
            pipe_pkg::FWD_WB:  op_a = wb_fwd_value;
            default:           op_a = ex_payload.a_val;
        endcase
        case (fwd_b_sel)
            pipe_pkg::FWD_MEM: op_b = mem_fwd_value;
            pipe_pkg::FWD_WB:  op_b = wb_fwd_value;
            default:           op_b = ex_payload.b_val;
        endcase
    end

    assign imm_zext = pipe_pkg::data_t'(ex_payload.imm);
    assign imm_sext = pipe_pkg::data_t'(signed'(ex_payload.imm));

    always_comb begin
        mem_payload.op            = ex_payload.op;
        mem_payload.rd            = ex_payload.rd;
        mem_payload.store_data    = op_a;
        mem_payload.tag           = ex_payload.tag;
        mem_payload.fetch_stalls  = ex_payload.fetch_stalls;
        mem_payload.decode_stalls = ex_payload.decode_stalls;
        mem_payload.we            = 1'b1;
        // All arithmetic wraps at the word width
        case (ex_payload.op)
            pipe_pkg::LI:   mem_payload.result = imm_zext;
            pipe_pkg::ADDI: mem_payload.result = op_a + imm_sext;
            pipe_pkg::ADD:  mem_payload.result = op_a + op_b;
            pipe_pkg::SUB:  mem_payload.result = op_a - op_b;
            pipe_pkg::LD:   mem_payload.result = imm_zext;
            pipe_pkg::ST: begin
                mem_payload.result = imm_zext;
                mem_payload.we     = 1'b0;
            end
            default: begin
                mem_payload.result = '0;
                mem_payload.we     = 1'b0;
            end
        endcase
    end

endmodule

//--- verilog/data_memory.sv
`include "pipe_config.svh"

module data_memory (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   mem_valid,
    input  pipe_pkg::mem_payload_t mem_payload,
    output pipe_pkg::wb_payload_t  wb_payload
);

    pipe_pkg::data_t                    mem [`PIPE_MEM_DEPTH];
    logic [$clog2(`PIPE_MEM_DEPTH)-1:0] addr;

    assign addr = mem_payload.result[$clog2(`PIPE_MEM_DEPTH)-1:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `PIPE_MEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (mem_valid && mem_payload.op == pipe_pkg::ST) begin
            mem[addr] <= mem_payload.store_data;
        end
    end

    // Value here also feeds the memory-stage forwarding path
    always_comb begin
        wb_payload.we            = mem_payload.we;
        wb_payload.rd            = mem_payload.rd;
        wb_payload.tag           = mem_payload.tag;
        wb_payload.fetch_stalls  = mem_payload.fetch_stalls;
        wb_payload.decode_stalls = mem_payload.decode_stalls;
        case (mem_payload.op)
            pipe_pkg::LD: wb_payload.value = mem[addr];
            pipe_pkg::ST: wb_payload.value = mem_payload.store_data;
            default:      wb_payload.value = mem_payload.result;
        endcase
    end

endmodule

//--- verilog/pipeline_top.sv
module pipeline_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      instr_valid,
    input  logic [15:0]               instr,
    input  logic                      stall,
    output logic                      retire_valid,
    output pipe_pkg::tag_t            retire_tag,
    output pipe_pkg::data_t           retire_result,
    output pipe_pkg::stall_cnt_t      retire_fetch_stalls,
    output pipe_pkg::stall_cnt_t      retire_decode_stalls
);

    logic                   front_hold;
    logic                   ex_bubble;

    pipe_pkg::reg_idx_t     rf_addr_a;
    pipe_pkg::reg_idx_t     rf_addr_b;
    pipe_pkg::data_t        rf_data_a;
    pipe_pkg::data_t        rf_data_b;

    logic                   dec_valid;
    pipe_pkg::ex_payload_t  dec_payload;
    logic                   ex_valid;
    pipe_pkg::ex_payload_t  ex_q;

    pipe_pkg::mem_payload_t ex_result;
    logic                   mem_valid;
    pipe_pkg::mem_payload_t mem_q;

    pipe_pkg::wb_payload_t  mem_result;
    pipe_pkg::wb_payload_t  wb_q;

    pipe_pkg::fwd_sel_t     fwd_a_sel;
    pipe_pkg::fwd_sel_t     fwd_b_sel;

    front_end front_end_i (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .hold        (front_hold),
        .rd_addr_a   (rf_addr_a),
        .rd_addr_b   (rf_addr_b),
        .rd_data_a   (rf_data_a),
        .rd_data_b   (rf_data_b),
        .ex_valid    (dec_valid),
        .ex_payload  (dec_payload)
    );

    // Written from the writeback stage, only while it holds an instruction
    register_file register_file_i (
        .clk     (clk),
        .rst     (rst),
        .we      (retire_valid & wb_q.we),
        .waddr   (wb_q.rd),
        .wdata   (wb_q.value),
        .raddr_a (rf_addr_a),
        .raddr_b (rf_addr_b),
        .rdata_a (rf_data_a),
        .rdata_b (rf_data_b)
    );

    pipeline_control pipeline_control_i (
        .stall      (stall),
        .front_hold (front_hold),
        .ex_bubble  (ex_bubble),
        .ex_rd      (ex_q.rd),
        .ex_rs      (ex_q.rs),
        .mem_valid  (mem_valid),
        .mem_writes (mem_q.we),
        .mem_rd     (mem_q.rd),
        .wb_valid   (retire_valid),
        .wb_writes  (wb_q.we),
        .wb_rd      (wb_q.rd),
        .fwd_a_sel  (fwd_a_sel),
        .fwd_b_sel  (fwd_b_sel)
    );

    stage_reg #(.payload_t(pipe_pkg::ex_payload_t)) ex_stage_i (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (dec_valid),
        .in_payload  (dec_payload),
        .bubble      (ex_bubble),
        .out_valid   (ex_valid),
        .out_payload (ex_q)
    );

    execute_unit execute_unit_i (
        .ex_payload    (ex_q),
        .fwd_a_sel     (fwd_a_sel),
        .fwd_b_sel     (fwd_b_sel),
        .mem_fwd_value (mem_result.value),
        .wb_fwd_value  (wb_q.value),
        .mem_payload   (ex_result)
    );

    // Back end never stalls
    stage_reg #(.payload_t(pipe_pkg::mem_payload_t)) mem_stage_i (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (ex_valid),
        .in_payload  (ex_result),
        .bubble      (1'b0),
        .out_valid   (mem_valid),
        .out_payload (mem_q)
    );

    data_memory data_memory_i (
        .clk         (clk),
        .rst         (rst),
        .mem_valid   (mem_valid),
        .mem_payload (mem_q),
        .wb_payload  (mem_result)
    );

    stage_reg #(.payload_t(pipe_pkg::wb_payload_t)) wb_stage_i (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (mem_valid),
        .in_payload  (mem_result),
        .bubble      (1'b0),
        .out_valid   (retire_valid),
        .out_payload (wb_q)
    );

    assign retire_tag           = wb_q.tag;
    assign retire_result        = wb_q.value;
    assign retire_fetch_stalls  = wb_q.fetch_stalls;
    assign retire_decode_stalls = wb_q.decode_stalls;

endmodule

//--- testbench/tb_clock.sv
module tb_clock #(
    parameter int PERIOD_NS = 4
) (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Two rising edges in reset, released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

//--- testbench/pipeline_asserts.sv
module pipeline_asserts (
    input logic clk,
    input logic rst,
    input logic stall,
    input logic ex_valid,
    input logic rf_we,
    input logic retire_valid
);
    timeunit 1ns;
    timeprecision 100ps;

    // A stalled edge loads a bubble into execute
    stall_empties_execute: assert property (
        @(posedge clk) disable iff (rst) stall |=> !ex_valid
    ) else $error("Valid instruction in execute after a stalled edge");

    // Register file writes come only from a valid writeback stage
    rf_write_needs_wb: assert property (
        @(posedge clk) disable iff (rst) rf_we |-> retire_valid
    ) else $error("Register file written without a valid writeback stage");

    reset_release_quiet: assert property (
        @(posedge clk) $fell(rst) |-> !retire_valid
    ) else $error("retire_valid high in the first cycle after reset");

endmodule

//--- testbench/pipeline_tb.sv
`include "pipe_config.svh"

module pipeline_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_INSTR   = 256;
    localparam int DRAIN_LIMIT = 200;
    localparam int STALL_MAX   = (1 << `PIPE_STALL_W) - 1;

    logic                 clk;
    logic                 rst;
    logic                 instr_valid;
    logic [15:0]          instr;
    logic                 stall;
    logic                 retire_valid;
    pipe_pkg::tag_t       retire_tag;
    pipe_pkg::data_t      retire_result;
    pipe_pkg::stall_cnt_t retire_fetch_stalls;
    pipe_pkg::stall_cnt_t retire_decode_stalls;

    int mismatches   = 0;
    int other_errors = 0;
    int cycle        = 0;
    int accepted     = 0;
    int retired      = 0;
    int fetch_slot   = -1;
    int decode_slot  = -1;
    logic [31:0] lfsr = 32'd96717;

    // Reference machine state updated in program order on acceptance
    pipe_pkg::data_t model_regs [`PIPE_REGS];
    pipe_pkg::data_t model_mem [`PIPE_MEM_DEPTH];
    pipe_pkg::tag_t  model_tag;

    // Expected and observed record per accepted instruction
    pipe_pkg::tag_t  exp_tag [MAX_INSTR];
    pipe_pkg::data_t exp_result [MAX_INSTR];
    int              exp_accept_cycle [MAX_INSTR];
    int              exp_fetch_stalls [MAX_INSTR];
    int              exp_decode_stalls [MAX_INSTR];
    pipe_pkg::tag_t  got_tag [MAX_INSTR];
    int              got_fetch [MAX_INSTR];
    int              got_decode [MAX_INSTR];
    int              got_latency [MAX_INSTR];

    tb_clock tb_clock_i (
        .clk (clk),
        .rst (rst)
    );

    pipeline_top pipeline_top_i (
        .clk                  (clk),
        .rst                  (rst),
        .instr_valid          (instr_valid),
        .instr                (instr),
        .stall                (stall),
        .retire_valid         (retire_valid),
        .retire_tag           (retire_tag),
        .retire_result        (retire_result),
        .retire_fetch_stalls  (retire_fetch_stalls),
        .retire_decode_stalls (retire_decode_stalls)
    );

    bind pipeline_top pipeline_asserts pipeline_asserts_i (
        .clk          (clk),
        .rst          (rst),
        .stall        (stall),
        .ex_valid     (ex_valid),
        .rf_we        (register_file_i.we),
        .retire_valid (retire_valid)
    );

    function automatic logic next_bit();
        logic out;
        out = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) begin
            lfsr = lfsr ^ 32'h80200003;
        end
        return out;
    endfunction

    function automatic logic [15:0] take_bits(input int n);
        logic [15:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[14:0], next_bit()};
        end
        return r;
    endfunction

    function automatic logic [15:0] encode_reg(input pipe_pkg::opcode_t op,
                                               input logic [2:0] rd, input logic [2:0] rs);
        return {op, rd, rs, 7'h00};
    endfunction

    function automatic logic [15:0] encode_imm(input pipe_pkg::opcode_t op,
                                               input logic [2:0] rd, input logic [7:0] imm);
        return {op, rd, 2'b00, imm};
    endfunction

    function automatic logic [15:0] random_instr();
        logic [15:0]       r;
        pipe_pkg::opcode_t op;
        logic [2:0]        rd;
        logic [2:0]        rs;
        logic [7:0]        imm;
        r = take_bits(3);
        if (r[2:0] == 3'd7) begin
            op = pipe_pkg::ADD;
        end else begin
            op = pipe_pkg::opcode_t'(r[2:0]);
        end
        r = take_bits(3);
        rd = r[2:0];
        r = take_bits(3);
        rs = r[2:0];
        r = take_bits(8);
        imm = r[7:0];
        // Few addresses so loads often hit earlier stores
        if (op == pipe_pkg::LD || op == pipe_pkg::ST) begin
            imm = {4'h0, imm[3:0]};
        end
        if (op == pipe_pkg::ADD || op == pipe_pkg::SUB) begin
            return encode_reg(op, rd, rs);
        end
        return encode_imm(op, rd, imm);
    endfunction

    // Applies one instruction to the model and returns its retired value
    function automatic pipe_pkg::data_t apply_instr(input logic [15:0] word);
        pipe_pkg::opcode_t  op;
        pipe_pkg::reg_idx_t rd;
        pipe_pkg::reg_idx_t rs;
        logic [7:0]         imm;
        pipe_pkg::data_t    value;
        op = pipe_pkg::opcode_t'(word[15:13]);
        rd = word[12:10];
        rs = word[9:7];
        imm = word[7:0];
        value = '0;
        case (op)
            pipe_pkg::LI:   value = {8'h00, imm};
            pipe_pkg::ADDI: value = model_regs[rd] + {{8{imm[7]}}, imm};
            pipe_pkg::ADD:  value = model_regs[rd] + model_regs[rs];
            pipe_pkg::SUB:  value = model_regs[rd] - model_regs[rs];
            pipe_pkg::LD:   value = model_mem[imm];
            pipe_pkg::ST:   value = model_regs[rd];
            default:        value = '0;
        endcase
        if (op == pipe_pkg::ST) begin
            model_mem[imm] = value;
        end else if (op != pipe_pkg::NOP) begin
            model_regs[rd] = value;
        end
        return value;
    endfunction

    function automatic int saturate(input int n);
        if (n > STALL_MAX) begin
            return STALL_MAX;
        end
        return n;
    endfunction

    // A stalled edge charges whoever sits in fetch and decode
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            cycle = 0;
            accepted = 0;
            fetch_slot = -1;
            decode_slot = -1;
            model_tag = '0;
            for (int i = 0; i < `PIPE_REGS; i++) begin
                model_regs[i] = '0;
            end
            for (int i = 0; i < `PIPE_MEM_DEPTH; i++) begin
                model_mem[i] = '0;
            end
        end else begin
            cycle = cycle + 1;
            if (stall) begin
                if (fetch_slot >= 0) begin
                    exp_fetch_stalls[fetch_slot]++;
                end
                if (decode_slot >= 0) begin
                    exp_decode_stalls[decode_slot]++;
                end
            end else begin
                decode_slot = fetch_slot;
                fetch_slot = -1;
                if (instr_valid) begin
                    exp_tag[accepted] = model_tag;
                    exp_result[accepted] = apply_instr(instr);
                    exp_accept_cycle[accepted] = cycle;
                    exp_fetch_stalls[accepted] = 0;
                    exp_decode_stalls[accepted] = 0;
                    fetch_slot = accepted;
                    accepted++;
                    model_tag++;
                end
            end
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("Mismatch at %0t ns: %s expected 0x%0h, got 0x%0h",
                 $time, name, expected, actual);
        mismatches++;
    endtask

    task automatic check_retire();
        int                   seq;
        int                   exp_latency;
        int                   latency;
        pipe_pkg::stall_cnt_t exp_fetch;
        pipe_pkg::stall_cnt_t exp_decode;
        seq = retired;
        if (seq >= accepted) begin
            $display("Error at %0t ns: retire_valid high with no instruction outstanding", $time);
            other_errors++;
        end else begin
            exp_latency = 4 + exp_fetch_stalls[seq] + exp_decode_stalls[seq];
            latency = cycle - exp_accept_cycle[seq];
            exp_fetch = pipe_pkg::stall_cnt_t'(saturate(exp_fetch_stalls[seq]));
            exp_decode = pipe_pkg::stall_cnt_t'(saturate(exp_decode_stalls[seq]));
            if (retire_tag !== exp_tag[seq]) begin
                report_mismatch("retire_tag", 32'(exp_tag[seq]), 32'(retire_tag));
            end
            if (retire_result !== exp_result[seq]) begin
                report_mismatch("retire_result", 32'(exp_result[seq]), 32'(retire_result));
            end
            if (retire_fetch_stalls !== exp_fetch) begin
                report_mismatch("retire_fetch_stalls", 32'(exp_fetch),
                                32'(retire_fetch_stalls));
            end
            if (retire_decode_stalls !== exp_decode) begin
                report_mismatch("retire_decode_stalls", 32'(exp_decode),
                                32'(retire_decode_stalls));
            end
            if (latency != exp_latency) begin
                report_mismatch("retire_valid latency", exp_latency, latency);
            end
            got_tag[seq] = retire_tag;
            got_fetch[seq] = int'(retire_fetch_stalls);
            got_decode[seq] = int'(retire_decode_stalls);
            got_latency[seq] = latency;
            retired++;
        end
    endtask

    always @(negedge clk) begin
        if (!rst && retire_valid) begin
            check_retire();
        end
    end

    task automatic step(input logic valid, input logic [15:0] word, input logic hold);
        instr_valid = valid;
        instr = word;
        stall = hold;
        @(negedge clk);
    endtask

    task automatic issue(input logic [15:0] word);
        step(1'b1, word, 1'b0);
    endtask

    task automatic wait_drain(input string what);
        int waited;
        waited = 0;
        instr_valid = 1'b0;
        stall = 1'b0;
        while (retired < accepted && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (retired < accepted) begin
            $display("Error at %0t ns: %s did not drain, %0d of %0d retired",
                     $time, what, retired, accepted);
            other_errors++;
        end
    endtask

    task automatic reset_idle();
        for (int i = 0; i < 6; i++) begin
            if (retire_valid !== 1'b0) begin
                report_mismatch("retire_valid", 0, 32'(retire_valid));
            end
            step(1'b0, 16'h0000, 1'b0);
        end
        // Reads of never-written registers retire as zero
        issue(encode_imm(pipe_pkg::ST, 3'd1, 8'h10));
        issue(encode_imm(pipe_pkg::ST, 3'd7, 8'h20));
        issue(encode_reg(pipe_pkg::ADD, 3'd2, 3'd3));
        wait_drain("reset program");
    endtask

    task automatic straight_line();
        issue(encode_imm(pipe_pkg::LI, 3'd1, 8'h34));
        issue(encode_imm(pipe_pkg::LI, 3'd2, 8'h05));
        issue(encode_imm(pipe_pkg::ADDI, 3'd1, 8'hFF));
        issue(encode_reg(pipe_pkg::SUB, 3'd1, 3'd2));
        issue(encode_imm(pipe_pkg::ADDI, 3'd3, 8'h7F));
        issue(encode_reg(pipe_pkg::SUB, 3'd3, 3'd1));
        issue(encode_imm(pipe_pkg::LI, 3'd4, 8'h00));
        issue(encode_reg(pipe_pkg::SUB, 3'd4, 3'd2));
        wait_drain("straight-line program");
    endtask

    task automatic forwarding_chains();
        issue(encode_imm(pipe_pkg::LI, 3'd1, 8'h03));
        issue(encode_reg(pipe_pkg::ADD, 3'd1, 3'd1));
        issue(encode_reg(pipe_pkg::ADD, 3'd1, 3'd1));
        issue(encode_reg(pipe_pkg::ADD, 3'd2, 3'd1));
        issue(encode_reg(pipe_pkg::SUB, 3'd2, 3'd1));
        issue(encode_imm(pipe_pkg::ST, 3'd2, 8'h40));
        issue(encode_imm(pipe_pkg::LD, 3'd5, 8'h40));
        issue(encode_reg(pipe_pkg::ADD, 3'd5, 3'd5));
        issue(encode_imm(pipe_pkg::LD, 3'd6, 8'h40));
        issue(encode_imm(pipe_pkg::ADDI, 3'd6, 8'h81));
        issue(encode_imm(pipe_pkg::LI, 3'd7, 8'hF0));
        issue(16'h0000);
        issue(16'h0000);
        // Producer three ahead reaches execute through register write-through
        issue(encode_reg(pipe_pkg::ADD, 3'd7, 3'd1));
        wait_drain("forwarding program");
    endtask

    task automatic store_load();
        issue(encode_imm(pipe_pkg::LI, 3'd1, 8'hAB));
        issue(encode_imm(pipe_pkg::ST, 3'd1, 8'h10));
        issue(encode_imm(pipe_pkg::LD, 3'd2, 8'h10));
        issue(encode_imm(pipe_pkg::LD, 3'd3, 8'h11));
        issue(encode_imm(pipe_pkg::LI, 3'd4, 8'h5A));
        issue(encode_imm(pipe_pkg::ST, 3'd4, 8'h11));
        issue(encode_imm(pipe_pkg::LD, 3'd5, 8'h11));
        issue(encode_imm(pipe_pkg::LD, 3'd6, 8'h10));
        issue(encode_reg(pipe_pkg::SUB, 3'd6, 3'd5));
        wait_drain("store and load program");
    endtask

    task automatic stall_counts(input int kf, input int kd);
        int             sx;
        pipe_pkg::tag_t next_tag;
        issue(encode_imm(pipe_pkg::ADDI, 3'd1, 8'h01));
        sx = accepted - 1;
        // Offers made while stalled must be dropped
        for (int i = 0; i < kf; i++) begin
            step(1'b1, encode_imm(pipe_pkg::LI, 3'd3, 8'hEE), 1'b1);
        end
        step(1'b0, 16'h0000, 1'b0);
        for (int i = 0; i < kd; i++) begin
            step(1'b1, encode_imm(pipe_pkg::LI, 3'd3, 8'hDD), 1'b1);
        end
        step(1'b0, 16'h0000, 1'b0);
        issue(encode_imm(pipe_pkg::LI, 3'd7, 8'h42));
        wait_drain("stall program");
        if (retired >= sx + 2) begin
            if (got_fetch[sx] != kf) begin
                report_mismatch("retire_fetch_stalls", kf, got_fetch[sx]);
            end
            if (got_decode[sx] != kd) begin
                report_mismatch("retire_decode_stalls", kd, got_decode[sx]);
            end
            if (got_latency[sx] != 4 + kf + kd) begin
                report_mismatch("retire_valid latency", 4 + kf + kd, got_latency[sx]);
            end
            next_tag = exp_tag[sx];
            next_tag++;
            if (got_tag[sx + 1] !== next_tag) begin
                report_mismatch("retire_tag", 32'(next_tag), 32'(got_tag[sx + 1]));
            end
        end
    endtask

    task automatic random_program(input int count);
        logic [15:0] word;
        logic        s;
        int          tries;
        for (int n = 0; n < count; n++) begin
            word = random_instr();
            tries = 0;
            // Offer until an unstalled edge takes it
            do begin
                s = next_bit() & next_bit();
                step(1'b1, word, s);
                tries++;
            end while (s && tries < 64);
            if (s) begin
                $display("Error at %0t ns: stall pattern never released", $time);
                other_errors++;
            end
        end
        wait_drain("random program");
    endtask

    task automatic finish_run();
        $display("Summary: %0d accepted, %0d retired, %0d mismatches, %0d other errors",
                 accepted, retired, mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    initial begin
        #100000;
        $display("Error at %0t ns: simulation watchdog expired", $time);
        other_errors++;
        finish_run();
    end

    initial begin
        int waited;
        instr_valid = 1'b0;
        instr = 16'h0000;
        stall = 1'b0;
        waited = 0;
        while (rst !== 1'b0 && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        if (rst !== 1'b0) begin
            $display("Error at %0t ns: reset never released", $time);
            other_errors++;
        end
        reset_idle();
        straight_line();
        forwarding_chains();
        store_load();
        stall_counts(3, 2);
        stall_counts(0, 5);
        random_program(40);
        finish_run();
    end

endmodule

//--- all.f
+incdir+common
common/pipe_pkg.sv
verilog/stage_reg.sv
verilog/pipeline_control.sv
front_end/register_file.sv
front_end/front_end.sv
verilog/execute_unit.sv
verilog/data_memory.sv
verilog/pipeline_top.sv
testbench/tb_clock.sv
testbench/pipeline_asserts.sv
testbench/pipeline_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module pipeline_tb -o pipeline_sim

status=0
./obj_dir/pipeline_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ]; then
    exit 1
fi
if grep -q "Errors found" sim.log; then
    exit 1
fi
exit 0
